// ==== rtl/tilegen_pkg.sv ====
package tilegen_pkg;

	////////////////////////////////////////////////////////////////////////////
	// vector types with a meaning of their own
	////////////////////////////////////////////////////////////////////////////

	// screen coordinate or scrolled plane coordinate
	typedef logic [7:0]  coord_t;
	// pattern number taken from a map entry
	typedef logic [7:0]  tile_idx_t;
	// tile map address {row, column}
	typedef logic [9:0]  map_addr_t;
	// map word {priority[15:13], colour[12:8], tile[7:0]}
	typedef logic [15:0] map_entry_t;
	// pattern row address {tile, fine y}
	typedef logic [10:0] pat_addr_t;
	// eight 3-bit dots, dot 0 in the low bits
	typedef logic [23:0] pat_row_t;
	// dot value 0 means transparent
	typedef logic [2:0]  dot_t;
	// palette group of a tile
	typedef logic [4:0]  colour_t;
	typedef logic [2:0]  prio_t;
	// final colour index handed to the palette
	typedef logic [7:0]  pixel_t;

	// cpu write port
	typedef logic [10:0] cpu_addr_t;
	typedef logic [23:0] cpu_data_t;

	////////////////////////////////////////////////////////////////////////////
	// selectors
	////////////////////////////////////////////////////////////////////////////

	// write target of a cpu access
	typedef enum logic [1:0] {
		SEL_MAP    = 2'd0,
		SEL_PAT    = 2'd1,
		SEL_SCROLL = 2'd2,
		SEL_BACK   = 2'd3
	} wsel_t;

	// which plane or the background produced a pixel
	typedef enum logic [1:0] {
		SRC_L0   = 2'd0,
		SRC_L1   = 2'd1,
		SRC_BACK = 2'd2
	} src_t;

	// number of tile planes on the board
	localparam int LAYER_CNT = 2;

endpackage

// ==== rtl/tile_layer.sv ====
`timescale 1ns/1ps

module tile_layer #(
	// plane number, matched against cpu_layer on writes
	parameter logic LAYER_ID = 1'b0
) (
	input  logic                   clk_6m,
	input  logic                   rst_n,

	// cpu write port, shared by both planes and the mixer
	input  logic                   cpu_we,
	input  tilegen_pkg::wsel_t     cpu_sel,
	input  logic                   cpu_layer,
	input  tilegen_pkg::cpu_addr_t cpu_addr,
	input  tilegen_pkg::cpu_data_t cpu_data,

	// pixel request, sampled on advance
	input  logic                   req_valid,
	input  tilegen_pkg::coord_t    req_x,
	input  tilegen_pkg::coord_t    req_y,
	input  logic                   advance,

	// stage 2 result towards the mixer
	output logic                   pix_valid,
	output tilegen_pkg::dot_t      pix_dot,
	output tilegen_pkg::colour_t   pix_colour,
	output tilegen_pkg::prio_t     pix_prio
);

	localparam int MAP_DEPTH = 1024;
	localparam int PAT_DEPTH = 2048;

	// write strobes for this plane
	logic layer_hit;
	logic map_we;
	logic pat_we;
	logic scroll_we;

	// scroll registers
	tilegen_pkg::coord_t scroll_x;
	tilegen_pkg::coord_t scroll_y;

	// tile map and pattern storage, no reset on contents
	tilegen_pkg::map_entry_t map_ram [MAP_DEPTH];
	tilegen_pkg::pat_row_t   pat_ram [PAT_DEPTH];

	// stage 1 lookup
	tilegen_pkg::coord_t     plane_x;
	tilegen_pkg::coord_t     plane_y;
	tilegen_pkg::map_addr_t  map_addr;
	logic                    s1_valid;
	tilegen_pkg::map_entry_t s1_entry;
	logic [2:0]              s1_fine_x;
	logic [2:0]              s1_fine_y;

	// stage 2 lookup
	tilegen_pkg::tile_idx_t  s1_tile;
	tilegen_pkg::pat_addr_t  pat_addr;
	tilegen_pkg::pat_row_t   pat_row;
	tilegen_pkg::dot_t       row_dot;

	////////////////////////////////////////////////////////////////////////////
	// cpu writes
	////////////////////////////////////////////////////////////////////////////

	assign layer_hit = cpu_we && (cpu_layer == LAYER_ID);
	assign map_we    = layer_hit && (cpu_sel == tilegen_pkg::SEL_MAP);
	assign pat_we    = layer_hit && (cpu_sel == tilegen_pkg::SEL_PAT);
	assign scroll_we = layer_hit && (cpu_sel == tilegen_pkg::SEL_SCROLL);

	// map word sits in the low 16 data bits
	always_ff @(posedge clk_6m) begin
		if (map_we)
			map_ram[cpu_addr[9:0]] <= cpu_data[15:0];
	end

	// a whole pattern row per write
	always_ff @(posedge clk_6m) begin
		if (pat_we)
			pat_ram[cpu_addr] <= cpu_data;
	end

	// address 0 is scroll x, address 1 is scroll y
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			scroll_x <= '0;
			scroll_y <= '0;
		end else if (scroll_we) begin
			if (cpu_addr == 11'd0)
				scroll_x <= cpu_data[7:0];
			else if (cpu_addr == 11'd1)
				scroll_y <= cpu_data[7:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 1, scroll and map lookup
	////////////////////////////////////////////////////////////////////////////

	// 8-bit add wraps mod 256 on its own
	assign plane_x  = req_x + scroll_x;
	assign plane_y  = req_y + scroll_y;
	// 32 x 32 tiles of 8 x 8 dots
	assign map_addr = {plane_y[7:3], plane_x[7:3]};

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else if (advance)
			s1_valid <= req_valid;
	end

	// entry and fine offsets only move on advance
	always_ff @(posedge clk_6m) begin
		if (advance) begin
			s1_entry  <= map_ram[map_addr];
			s1_fine_x <= plane_x[2:0];
			s1_fine_y <= plane_y[2:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2, pattern fetch and dot pick
	////////////////////////////////////////////////////////////////////////////

	assign s1_tile  = s1_entry[7:0];
	assign pat_addr = {s1_tile, s1_fine_y};
	assign pat_row  = pat_ram[pat_addr];
	// three bits per dot, dot 0 lowest
	assign row_dot  = pat_row[3 * s1_fine_x +: 3];

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			pix_valid <= 1'b0;
		else if (advance)
			pix_valid <= s1_valid;
	end

	// colour and priority travel with the dot
	always_ff @(posedge clk_6m) begin
		if (advance) begin
			pix_dot    <= row_dot;
			pix_colour <= s1_entry[12:8];
			pix_prio   <= s1_entry[15:13];
		end
	end

endmodule

// ==== rtl/layer_mixer.sv ====
`timescale 1ns/1ps

module layer_mixer (
	input  logic                   clk_6m,
	input  logic                   rst_n,

	// only background colour writes land here
	input  logic                   cpu_we,
	input  tilegen_pkg::wsel_t     cpu_sel,
	input  tilegen_pkg::cpu_data_t cpu_data,

	// plane 0 stage 2
	input  logic                   l0_valid,
	input  tilegen_pkg::dot_t      l0_dot,
	input  tilegen_pkg::colour_t   l0_colour,
	input  tilegen_pkg::prio_t     l0_prio,

	// plane 1 stage 2
	input  logic                   l1_valid,
	input  tilegen_pkg::dot_t      l1_dot,
	input  tilegen_pkg::colour_t   l1_colour,
	input  tilegen_pkg::prio_t     l1_prio,

	input  logic                   out_ready,
	output logic                   advance,
	output logic                   out_valid,
	output tilegen_pkg::pixel_t    out_pixel,
	output tilegen_pkg::src_t      out_src
);

	tilegen_pkg::pixel_t back_colour;
	logic                l0_opaque;
	logic                l1_opaque;
	logic                mix_valid;
	tilegen_pkg::pixel_t mix_pixel;
	tilegen_pkg::src_t   mix_src;

	// background colour latch
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			back_colour <= '0;
		else if (cpu_we && (cpu_sel == tilegen_pkg::SEL_BACK))
			back_colour <= cpu_data[7:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// priority select
	////////////////////////////////////////////////////////////////////////////

	assign l0_opaque = (l0_dot != 3'd0);
	assign l1_opaque = (l1_dot != 3'd0);
	// planes step in lock, both valids always agree
	assign mix_valid = l0_valid && l1_valid;

	always_comb begin
		mix_pixel = back_colour;
		mix_src   = tilegen_pkg::SRC_BACK;
		// ties go to plane 0
		if (l1_opaque && (!l0_opaque || (l1_prio > l0_prio))) begin
			mix_pixel = {l1_colour, l1_dot};
			mix_src   = tilegen_pkg::SRC_L1;
		end else if (l0_opaque) begin
			mix_pixel = {l0_colour, l0_dot};
			mix_src   = tilegen_pkg::SRC_L0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stall rule and output stage
	////////////////////////////////////////////////////////////////////////////

	// whole pipe moves when the output slot is free or drains
	assign advance = !out_valid || out_ready;

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= mix_valid;
	end

	// held while stalled
	always_ff @(posedge clk_6m) begin
		if (advance && mix_valid) begin
			out_pixel <= mix_pixel;
			out_src   <= mix_src;
		end
	end

endmodule

// ==== rtl/tilegen_top.sv ====
`timescale 1ns/1ps

module tilegen_top (
	input  logic                   clk_6m,
	input  logic                   rst_n,

	// cpu write port
	input  logic                   cpu_we,
	input  tilegen_pkg::wsel_t     cpu_sel,
	input  logic                   cpu_layer,
	input  tilegen_pkg::cpu_addr_t cpu_addr,
	input  tilegen_pkg::cpu_data_t cpu_data,

	// pixel requests
	input  logic                   in_valid,
	input  tilegen_pkg::coord_t    in_x,
	input  tilegen_pkg::coord_t    in_y,
	output logic                   in_ready,

	// mixed pixels
	output logic                   out_valid,
	output tilegen_pkg::pixel_t    out_pixel,
	output tilegen_pkg::src_t      out_src,
	input  logic                   out_ready
);

	// plane 0 towards the mixer
	logic                 l0_valid;
	tilegen_pkg::dot_t    l0_dot;
	tilegen_pkg::colour_t l0_colour;
	tilegen_pkg::prio_t   l0_prio;

	// plane 1 towards the mixer
	logic                 l1_valid;
	tilegen_pkg::dot_t    l1_dot;
	tilegen_pkg::colour_t l1_colour;
	tilegen_pkg::prio_t   l1_prio;

	////////////////////////////////////////////////////////////////////////////
	// tile planes, both see every request and step on in_ready
	////////////////////////////////////////////////////////////////////////////

	tile_layer #(.LAYER_ID(1'b0)) i_layer0 (
		.clk_6m     (clk_6m),
		.rst_n      (rst_n),
		.cpu_we     (cpu_we),
		.cpu_sel    (cpu_sel),
		.cpu_layer  (cpu_layer),
		.cpu_addr   (cpu_addr),
		.cpu_data   (cpu_data),
		.req_valid  (in_valid),
		.req_x      (in_x),
		.req_y      (in_y),
		.advance    (in_ready),
		.pix_valid  (l0_valid),
		.pix_dot    (l0_dot),
		.pix_colour (l0_colour),
		.pix_prio   (l0_prio)
	);

	tile_layer #(.LAYER_ID(1'b1)) i_layer1 (
		.clk_6m     (clk_6m),
		.rst_n      (rst_n),
		.cpu_we     (cpu_we),
		.cpu_sel    (cpu_sel),
		.cpu_layer  (cpu_layer),
		.cpu_addr   (cpu_addr),
		.cpu_data   (cpu_data),
		.req_valid  (in_valid),
		.req_x      (in_x),
		.req_y      (in_y),
		.advance    (in_ready),
		.pix_valid  (l1_valid),
		.pix_dot    (l1_dot),
		.pix_colour (l1_colour),
		.pix_prio   (l1_prio)
	);

	// priority mixer owns the stall and drives in_ready
	layer_mixer i_mixer (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.cpu_we    (cpu_we),
		.cpu_sel   (cpu_sel),
		.cpu_data  (cpu_data),
		.l0_valid  (l0_valid),
		.l0_dot    (l0_dot),
		.l0_colour (l0_colour),
		.l0_prio   (l0_prio),
		.l1_valid  (l1_valid),
		.l1_dot    (l1_dot),
		.l1_colour (l1_colour),
		.l1_prio   (l1_prio),
		.out_ready (out_ready),
		.advance   (in_ready),
		.out_valid (out_valid),
		.out_pixel (out_pixel),
		.out_src   (out_src)
	);

endmodule

// ==== sim/tilegen_sva.sv ====
`timescale 1ns/1ps

module tilegen_sva (
	input logic                clk_6m,
	input logic                rst_n,
	input logic                in_ready,
	input logic                out_valid,
	input logic                out_ready,
	input tilegen_pkg::pixel_t out_pixel,
	input tilegen_pkg::src_t   out_src
);

	////////////////////////////////////////////////////////////////////////////
	// reset and handshake rules
	////////////////////////////////////////////////////////////////////////////

	// first sampled cycle out of reset starts empty
	reset_empty: assert property (@(posedge clk_6m) $rose(rst_n) |-> !out_valid)
		else $error("out_valid high in the first cycle after reset");

	// a stalled result must not move
	stall_hold: assert property (@(posedge clk_6m) disable iff (!rst_n)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(out_pixel) && $stable(out_src)))
		else $error("output changed while stalled");

	// request side only blocked by a full, stalled output slot
	ready_rule: assert property (@(posedge clk_6m) disable iff (!rst_n)
		in_ready == !(out_valid && !out_ready))
		else $error("in_ready disagrees with the stall rule");

endmodule

// ==== sim/tb_tilegen.sv ====
`timescale 1ns/1ps

module tb_tilegen;

	// record kind sits in the top nibble of each golden line
	localparam logic [3:0] KIND_WRITE = 4'h1;
	localparam logic [3:0] KIND_PIXEL = 4'h2;
	localparam int         MAX_RECS   = 64;

	logic                   clk_6m = 1'b0;
	logic                   rst_n;
	logic                   cpu_we;
	tilegen_pkg::wsel_t     cpu_sel;
	logic                   cpu_layer;
	tilegen_pkg::cpu_addr_t cpu_addr;
	tilegen_pkg::cpu_data_t cpu_data;
	logic                   in_valid;
	tilegen_pkg::coord_t    in_x;
	tilegen_pkg::coord_t    in_y;
	logic                   in_ready;
	logic                   out_valid;
	tilegen_pkg::pixel_t    out_pixel;
	tilegen_pkg::src_t      out_src;
	logic                   out_ready = 1'b1;

	logic [47:0] golden [MAX_RECS];
	int          rec_cnt    = 0;
	int          req_cnt    = 0;
	int          res_cnt    = 0;
	int          pixel_errs = 0;
	int          src_errs   = 0;
	int          other_errs = 0;
	logic [31:0] lcg_state  = 32'd15174;

	// expected results in request order
	tilegen_pkg::pixel_t exp_pixel_q [$];
	tilegen_pkg::src_t   exp_src_q [$];

	tilegen_top i_dut (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.cpu_we    (cpu_we),
		.cpu_sel   (cpu_sel),
		.cpu_layer (cpu_layer),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.in_valid  (in_valid),
		.in_x      (in_x),
		.in_y      (in_y),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_pixel (out_pixel),
		.out_src   (out_src),
		.out_ready (out_ready)
	);

	bind tilegen_top tilegen_sva i_sva (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_pixel (out_pixel),
		.out_src   (out_src)
	);

	// 100 MHz stand-in for the 6 MHz dot clock
	initial begin
		forever #5 clk_6m = ~clk_6m;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_pixel(input tilegen_pkg::pixel_t exp_val,
			input tilegen_pkg::pixel_t act_val);
		if (act_val !== exp_val) begin
			$display("Fail at %0t: pixel expected %02h, got %02h", $time, exp_val, act_val);
			pixel_errs++;
		end
	endtask

	task automatic check_src(input tilegen_pkg::src_t exp_val,
			input tilegen_pkg::src_t act_val);
		if (act_val !== exp_val) begin
			$display("Fail at %0t: source expected %0d, got %0d", $time, exp_val, act_val);
			src_errs++;
		end
	endtask

	// one cycle write strobe from falling edge to falling edge
	task automatic cpu_write(input logic layer, input tilegen_pkg::wsel_t sel,
			input tilegen_pkg::cpu_addr_t addr, input tilegen_pkg::cpu_data_t data);
		cpu_we    = 1'b1;
		cpu_layer = layer;
		cpu_sel   = sel;
		cpu_addr  = addr;
		cpu_data  = data;
		@(negedge clk_6m);
		cpu_we = 1'b0;
	endtask

	// hold the request until the rising edge that takes it
	task automatic send_pixel(input tilegen_pkg::coord_t x, input tilegen_pkg::coord_t y,
			input tilegen_pkg::pixel_t exp_pix, input tilegen_pkg::src_t exp_src);
		in_valid = 1'b1;
		in_x     = x;
		in_y     = y;
		do
			@(posedge clk_6m);
		while (!in_ready);
		exp_pixel_q.push_back(exp_pix);
		exp_src_q.push_back(exp_src);
		req_cnt++;
		@(negedge clk_6m);
		in_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////////////////////

	// roughly one cycle in three without ready
	always @(negedge clk_6m) begin
		lcg_state = lcg_next(lcg_state);
		out_ready = (lcg_state[30:16] % 3) != 0;
	end

	always @(posedge clk_6m) begin
		if (rst_n && out_valid && out_ready) begin
			res_cnt++;
			if (exp_pixel_q.size() == 0) begin
				$display("unexpected result at %0t with no request outstanding", $time);
				other_errs++;
			end else begin
				check_pixel(exp_pixel_q.pop_front(), out_pixel);
				check_src(exp_src_q.pop_front(), out_src);
			end
		end
	end

	// limit scales with the golden record count
	initial begin
		wait (rec_cnt != 0);
		repeat (rec_cnt * 20 + 500) @(posedge clk_6m);
		$display("timeout after %0d cycles, the run did not finish", rec_cnt * 20 + 500);
		$display("TB FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [47:0] rec;
		int          i;
		int          cnt;
		int          drain;
		rst_n     = 1'b0;
		cpu_we    = 1'b0;
		cpu_sel   = tilegen_pkg::SEL_MAP;
		cpu_layer = 1'b0;
		cpu_addr  = '0;
		cpu_data  = '0;
		in_valid  = 1'b0;
		in_x      = '0;
		in_y      = '0;
		// unused slots keep kind 0 and carry their own index
		for (i = 0; i < MAX_RECS; i++)
			golden[i] = 48'(i);
		$readmemh("sim/tilegen_golden.hex", golden);
		// records run until the first unknown kind
		cnt = 0;
		while (cnt < MAX_RECS &&
				(golden[cnt][47:44] == KIND_WRITE || golden[cnt][47:44] == KIND_PIXEL))
			cnt++;
		rec_cnt = cnt;
		if (cnt == 0) begin
			$display("golden file holds no records");
			other_errs++;
		end
		repeat (16) @(posedge clk_6m);
		@(negedge clk_6m);
		rst_n = 1'b1;
		// idle pipe right out of reset
		@(posedge clk_6m);
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			$display("Fail at %0t: pipe not idle after reset", $time);
			other_errs++;
		end
		@(negedge clk_6m);
		for (i = 0; i < cnt; i++) begin
			rec = golden[i];
			if (rec[47:44] == KIND_WRITE)
				cpu_write(rec[40], tilegen_pkg::wsel_t'(rec[37:36]), rec[34:24], rec[23:0]);
			else
				send_pixel(rec[39:32], rec[31:24], rec[23:16], tilegen_pkg::src_t'(rec[9:8]));
		end
		// let the last results drain, then look for stragglers
		drain = 0;
		while (exp_pixel_q.size() != 0 && drain < 200) begin
			@(posedge clk_6m);
			drain++;
		end
		repeat (20) @(posedge clk_6m);
		if (exp_pixel_q.size() != 0) begin
			$display("%0d expected results never came out", exp_pixel_q.size());
			other_errs++;
		end
		if (res_cnt != req_cnt) begin
			$display("%0d requests sent but %0d results seen", req_cnt, res_cnt);
			other_errs++;
		end
		$display("errors: pixel %0d, source %0d, other %0d", pixel_errs, src_errs, other_errs);
		if (pixel_errs + src_errs + other_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sim/tilegen_golden.hex ====
// write: 1 L S AAA DDDDDD = kind, layer, selector, address, data
// pixel: 2 0 XX YY PP SS 00 = kind, pad, x, y, expected pixel, expected source, pad
// layer 1 scroll x 13, y 0A, background 2A
112000000013
11200100000A
10300000002A
// layer 0 map entries and pattern rows
100000004301
100041006401
100042006501
100043006601
1003FE000001
10100AFAC688
101008FAC688
// layer 1 map entries and pattern rows
110022000000
110023000000
110063007005
11006400B105
110065003205
110000004A05
111004000000
11102C053977
11102A053977
// layer 0 alone over a transparent layer 1
2000022A0200
200102190000
2003021B0000
2006021E0000
2007021F0000
// overlap, priority and single transparency
200812840100
200912210000
200A12220000
200C12240000
2010128C0100
2011128B0100
2012128A0100
201912310000
201B12330000
// coordinates wrapping past 255 on layer 1
20F0F8540100
20F2F8520100
20F3F8510100
20F4F8040000

// ==== compile.f ====
rtl/tilegen_pkg.sv
rtl/tile_layer.sv
rtl/layer_mixer.sv
rtl/tilegen_top.sv
sim/tilegen_sva.sv
sim/tb_tilegen.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_tilegen
FILELIST = compile.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run into sim.log, check for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
